// File: hw/wrc_settings.svh
`ifndef WRC_SETTINGS_SVH
`define WRC_SETTINGS_SVH

// Client side.
`define WRC_ADDR_W 34
`define WRC_DATA_W 16

// One line is one DDR2 beat.
`define WRC_LINE_W 128
`define WRC_MASK_W 16

// DDR2 command port.
`define WRC_DDR_ADDR_W 31

// Peer line buffers on the shared port.
`define WRC_NUM_CLIENTS 2

`endif

// File: hw/client_wr_pkg.sv
`include "wrc_settings.svh"

package client_wr_pkg;

  // Client write request fields.
  typedef logic [`WRC_ADDR_W-1:0]   wr_addr_t;
  typedef logic [`WRC_DATA_W-1:0]   wr_data_t;
  typedef logic [`WRC_DATA_W/8-1:0] wr_sel_t;

  // Upper address bits naming one line.
  typedef logic [`WRC_ADDR_W-$clog2(`WRC_MASK_W)-1:0] line_addr_t;

  // Line buffer collect states.
  // WR_DELAYED holds a missing write until the port frees up.
  // WR_COMMIT holds an eob flush until the port frees up.
  typedef enum logic [1:0] {
    WR_COLLECT,
    WR_DELAYED,
    WR_COMMIT
  } collect_state_e;

endpackage

// File: hw/ddr_wr_pkg.sv
`include "wrc_settings.svh"

package ddr_wr_pkg;

  // DDR2 write port fields.
  typedef logic [`WRC_LINE_W-1:0]     ddr_line_t;
  typedef logic [`WRC_MASK_W-1:0]     ddr_mask_t;
  typedef logic [`WRC_DDR_ADDR_W-1:0] ddr_addr_t;

  // Burst sender, data beat then address beat.
  typedef enum logic {
    SEND_IDLE,
    SEND_SECOND
  } send_state_e;

  // Index of the buffer owning the port.
  typedef logic [$clog2(`WRC_NUM_CLIENTS)-1:0] client_id_t;

endpackage

// File: hw/ddr_wr_if.sv
`timescale 1ns/1ps

interface ddr_wr_if
  import ddr_wr_pkg::*;
();

  // Beats from one line buffer.
  ddr_line_t data;
  ddr_mask_t mask;
  logic      data_wen;
  ddr_addr_t addr;
  logic      addr_wen;
  logic      send_req;

  // FIFO stall levels as this buffer sees them.
  logic      af_afull;
  logic      df_afull;

  modport buffer (
    output data, mask, data_wen, addr, addr_wen, send_req,
    input  af_afull, df_afull
  );

  modport arbiter (
    input  data, mask, data_wen, addr, addr_wen, send_req,
    output af_afull, df_afull
  );

endinterface

// File: hw/mem_wr_cache.sv
`timescale 1ns/1ps
`include "wrc_settings.svh"

module mem_wr_cache
  import client_wr_pkg::*;
  import ddr_wr_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  wr_sel_t  wr_sel_i,
  input  logic     wr_strb_i,
  input  wr_addr_t wr_addr_i,
  input  wr_data_t wr_data_i,
  input  logic     wr_eob_i,
  output logic     wr_ack_o,
  ddr_wr_if.buffer ddr
);

  localparam int SEL_W    = `WRC_DATA_W / 8;
  localparam int OFF_LSB  = $clog2(SEL_W);
  localparam int LINE_LSB = $clog2(`WRC_MASK_W);

  collect_state_e collect_state;
  send_state_e    send_state;

  logic       buffer_empty;
  line_addr_t buffer_addr;
  ddr_line_t  data_buffer;
  ddr_mask_t  mask_buffer;
  line_addr_t addr_buff;

  line_addr_t                  wr_line_addr;
  logic [LINE_LSB-OFF_LSB-1:0] wr_offset;
  ddr_line_t                   data_overlay;
  ddr_mask_t                   mask_overlay;
  ddr_line_t                   merge_base;
  ddr_line_t                   data_next;

  logic buffer_hit;
  logic send_busy;
  logic send_wait;
  logic port_free;
  logic send_start;

  assign wr_line_addr = wr_addr_i[`WRC_ADDR_W-1:LINE_LSB];
  assign wr_offset    = wr_addr_i[LINE_LSB-1:OFF_LSB];
  assign buffer_hit   = buffer_empty || (buffer_addr == wr_line_addr);

  // Halfword and selects shifted to their slot in the line.
  assign data_overlay = ddr_line_t'(wr_data_i) << (`WRC_DATA_W * wr_offset);
  assign mask_overlay = ddr_mask_t'(wr_sel_i) << (SEL_W * wr_offset);

  // A fresh line starts from zero.
  assign merge_base = (collect_state == WR_COLLECT && buffer_hit && !buffer_empty) ?
                      data_buffer : '0;

  always_comb begin
    for (int b = 0; b < `WRC_MASK_W; b++) begin
      data_next[8*b +: 8] = mask_overlay[b] ? data_overlay[8*b +: 8] : merge_base[8*b +: 8];
    end
  end

  // Sender status.
  assign send_busy = (send_state == SEND_SECOND);
  assign send_wait = send_busy ? (ddr.af_afull | ddr.df_afull) : ddr.df_afull;
  assign port_free = ~send_wait & ~send_busy;

  // Buffered line must go out now.
  always_comb begin
    case (collect_state)
      WR_COLLECT: send_start = wr_strb_i ? ~buffer_hit : (wr_eob_i & ~buffer_empty);
      default:    send_start = 1'b1;
    endcase
  end

  always_comb begin
    case (collect_state)
      WR_COMMIT:  wr_ack_o = 1'b0;
      WR_DELAYED: wr_ack_o = wr_strb_i & port_free;
      default:    wr_ack_o = wr_strb_i & (buffer_hit | port_free);
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      collect_state <= WR_COLLECT;
      buffer_empty  <= 1'b1;
      mask_buffer   <= '0;
    end else begin
      case (collect_state)
        WR_COLLECT: begin
          if (wr_strb_i) begin
            if (buffer_hit) begin
              buffer_empty <= 1'b0;
              buffer_addr  <= wr_line_addr;
              data_buffer  <= data_next;
              mask_buffer  <= mask_buffer | mask_overlay;
            end else if (port_free) begin
              // Old line leaves this cycle.
              buffer_addr <= wr_line_addr;
              data_buffer <= data_next;
              mask_buffer <= mask_overlay;
            end else begin
              collect_state <= WR_DELAYED;
            end
          end else if (wr_eob_i && !buffer_empty) begin
            if (port_free) begin
              buffer_empty <= 1'b1;
              mask_buffer  <= '0;
            end else begin
              collect_state <= WR_COMMIT;
            end
          end
        end
        WR_DELAYED: begin
          if (port_free && wr_strb_i) begin
            collect_state <= WR_COLLECT;
            buffer_empty  <= 1'b0;
            buffer_addr   <= wr_line_addr;
            data_buffer   <= data_next;
            mask_buffer   <= mask_overlay;
          end
        end
        WR_COMMIT: begin
          if (port_free) begin
            collect_state <= WR_COLLECT;
            buffer_empty  <= 1'b1;
            mask_buffer   <= '0;
          end
        end
        default: collect_state <= WR_COLLECT;
      endcase
    end
  end

  // Two beat burst, line with mask then address with zero mask.
  assign ddr.data_wen = ~send_wait & (send_busy | send_start);
  assign ddr.addr_wen = ~send_wait & send_busy;
  assign ddr.data     = data_buffer;
  assign ddr.mask     = send_busy ? '0 : mask_buffer;
  assign ddr.addr     = {addr_buff, 1'b0};
  assign ddr.send_req = send_busy | send_start;

  always_ff @(posedge clk) begin
    if (reset) begin
      send_state <= SEND_IDLE;
    end else begin
      case (send_state)
        SEND_IDLE: begin
          if (ddr.data_wen) begin
            send_state <= SEND_SECOND;
          end
        end
        SEND_SECOND: begin
          if (ddr.addr_wen) begin
            send_state <= SEND_IDLE;
          end
        end
        default: send_state <= SEND_IDLE;
      endcase
    end
  end

  // Line address kept for the address beat.
  always_ff @(posedge clk) begin
    if (send_state == SEND_IDLE && ddr.data_wen) begin
      addr_buff <= buffer_addr;
    end
  end

endmodule

// File: hw/ddr_wr_arbiter.sv
`timescale 1ns/1ps
`include "wrc_settings.svh"

module ddr_wr_arbiter
  import ddr_wr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  ddr_wr_if.arbiter port0,
  ddr_wr_if.arbiter port1,
  output ddr_line_t ddr_data_o,
  output ddr_mask_t ddr_mask_o,
  output logic      ddr_data_wen_o,
  output ddr_addr_t ddr_addr_o,
  output logic      ddr_addr_wen_o,
  input  logic      ddr_af_afull_i,
  input  logic      ddr_df_afull_i
);

  logic [`WRC_NUM_CLIENTS-1:0] req;

  client_id_t owner_q;
  client_id_t owner;
  client_id_t rr_q;
  logic       locked_q;
  logic       done_q;
  logic       hold;

  assign req = {port1.send_req, port0.send_req};

  // Owner keeps the port through its burst and while it still asks.
  assign hold = locked_q | (req[owner_q] & ~done_q);

  always_comb begin
    owner = owner_q;
    if (!hold) begin
      if (req[rr_q]) begin
        owner = rr_q;
      end else if (req[~rr_q]) begin
        owner = ~rr_q;
      end
    end
  end

  // Non-owner sees full FIFOs and stalls.
  assign port0.af_afull = (owner == client_id_t'(0)) ? ddr_af_afull_i : 1'b1;
  assign port0.df_afull = (owner == client_id_t'(0)) ? ddr_df_afull_i : 1'b1;
  assign port1.af_afull = (owner == client_id_t'(1)) ? ddr_af_afull_i : 1'b1;
  assign port1.df_afull = (owner == client_id_t'(1)) ? ddr_df_afull_i : 1'b1;

  always_comb begin
    if (owner == client_id_t'(1)) begin
      ddr_data_o     = port1.data;
      ddr_mask_o     = port1.mask;
      ddr_data_wen_o = port1.data_wen;
      ddr_addr_o     = port1.addr;
      ddr_addr_wen_o = port1.addr_wen;
    end else begin
      ddr_data_o     = port0.data;
      ddr_mask_o     = port0.mask;
      ddr_data_wen_o = port0.data_wen;
      ddr_addr_o     = port0.addr;
      ddr_addr_wen_o = port0.addr_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      owner_q  <= '0;
      rr_q     <= '0;
      locked_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      owner_q <= owner;
      done_q  <= ddr_addr_wen_o;
      if (ddr_addr_wen_o) begin
        // Burst done, the other buffer goes first next.
        locked_q <= 1'b0;
        rr_q     <= ~owner;
      end else if (ddr_data_wen_o) begin
        locked_q <= 1'b1;
      end
    end
  end

endmodule

// File: hw/ddr_wr_top.sv
`timescale 1ns/1ps

module ddr_wr_top
  import client_wr_pkg::*;
  import ddr_wr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  wr_sel_t   wr0_sel_i,
  input  logic      wr0_strb_i,
  input  wr_addr_t  wr0_addr_i,
  input  wr_data_t  wr0_data_i,
  input  logic      wr0_eob_i,
  output logic      wr0_ack_o,

  input  wr_sel_t   wr1_sel_i,
  input  logic      wr1_strb_i,
  input  wr_addr_t  wr1_addr_i,
  input  wr_data_t  wr1_data_i,
  input  logic      wr1_eob_i,
  output logic      wr1_ack_o,

  output ddr_line_t ddr_data_o,
  output ddr_mask_t ddr_mask_o,
  output logic      ddr_data_wen_o,
  output ddr_addr_t ddr_addr_o,
  output logic      ddr_addr_wen_o,
  input  logic      ddr_af_afull_i,
  input  logic      ddr_df_afull_i
);

  ddr_wr_if port0_if ();
  ddr_wr_if port1_if ();

  mem_wr_cache cache0 (
    .clk       (clk),
    .reset     (reset),
    .wr_sel_i  (wr0_sel_i),
    .wr_strb_i (wr0_strb_i),
    .wr_addr_i (wr0_addr_i),
    .wr_data_i (wr0_data_i),
    .wr_eob_i  (wr0_eob_i),
    .wr_ack_o  (wr0_ack_o),
    .ddr       (port0_if.buffer)
  );

  mem_wr_cache cache1 (
    .clk       (clk),
    .reset     (reset),
    .wr_sel_i  (wr1_sel_i),
    .wr_strb_i (wr1_strb_i),
    .wr_addr_i (wr1_addr_i),
    .wr_data_i (wr1_data_i),
    .wr_eob_i  (wr1_eob_i),
    .wr_ack_o  (wr1_ack_o),
    .ddr       (port1_if.buffer)
  );

  ddr_wr_arbiter arbiter (
    .clk            (clk),
    .reset          (reset),
    .port0          (port0_if.arbiter),
    .port1          (port1_if.arbiter),
    .ddr_data_o     (ddr_data_o),
    .ddr_mask_o     (ddr_mask_o),
    .ddr_data_wen_o (ddr_data_wen_o),
    .ddr_addr_o     (ddr_addr_o),
    .ddr_addr_wen_o (ddr_addr_wen_o),
    .ddr_af_afull_i (ddr_af_afull_i),
    .ddr_df_afull_i (ddr_df_afull_i)
  );

endmodule

// File: testbench/ddr_wr_tb.sv
`timescale 1ns/1ps
`include "wrc_settings.svh"

module ddr_wr_tb
  import client_wr_pkg::*;
  import ddr_wr_pkg::*;
();

  logic      clk;
  logic      reset;
  wr_sel_t   wr_sel [2];
  logic      wr_strb [2];
  wr_addr_t  wr_addr [2];
  wr_data_t  wr_data [2];
  logic      wr_eob [2];
  logic      wr_ack [2];
  ddr_line_t ddr_data;
  ddr_mask_t ddr_mask;
  logic      ddr_data_wen;
  ddr_addr_t ddr_addr;
  logic      ddr_addr_wen;
  logic      af_afull;
  logic      df_afull;

  int unsigned cycle;
  int unsigned limit;
  int unsigned af_until;
  int unsigned df_until;
  int          errs;
  int          mon_errs;
  string       test_name;

  // Bursts seen on the DDR port.
  ddr_line_t cap_line[$];
  ddr_mask_t cap_mask[$];
  ddr_addr_t cap_addr[$];
  ddr_line_t first_line;
  ddr_mask_t first_mask;
  logic      in_burst;

  ddr_wr_top ddr_wr_top_i (
    .clk            (clk),
    .reset          (reset),
    .wr0_sel_i      (wr_sel[0]),
    .wr0_strb_i     (wr_strb[0]),
    .wr0_addr_i     (wr_addr[0]),
    .wr0_data_i     (wr_data[0]),
    .wr0_eob_i      (wr_eob[0]),
    .wr0_ack_o      (wr_ack[0]),
    .wr1_sel_i      (wr_sel[1]),
    .wr1_strb_i     (wr_strb[1]),
    .wr1_addr_i     (wr_addr[1]),
    .wr1_data_i     (wr_data[1]),
    .wr1_eob_i      (wr_eob[1]),
    .wr1_ack_o      (wr_ack[1]),
    .ddr_data_o     (ddr_data),
    .ddr_mask_o     (ddr_mask),
    .ddr_data_wen_o (ddr_data_wen),
    .ddr_addr_o     (ddr_addr),
    .ddr_addr_wen_o (ddr_addr_wen),
    .ddr_af_afull_i (af_afull),
    .ddr_df_afull_i (df_afull)
  );

  always #2 clk = ~clk;

  // Stall windows and the run limit.
  always @(posedge clk) begin
    cycle    <= cycle + 1;
    af_afull <= (cycle < af_until);
    df_afull <= (cycle < df_until);
    if (limit != 0 && cycle >= limit) begin
      $display("timeout after %0d cycles in test %s", cycle, test_name);
      $display("Test FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (reset) begin
      if (ddr_data_wen || ddr_addr_wen) begin
        $display("write enable high during reset in test %s", test_name);
        mon_errs++;
      end
    end else if (ddr_data_wen && df_afull) begin
      $display("data beat sent while data FIFO almost full in test %s", test_name);
      mon_errs++;
    end
    if (!reset && ddr_addr_wen) begin
      if (!in_burst) begin
        $display("address beat without a first beat in test %s", test_name);
        mon_errs++;
      end
      if (ddr_mask != '0) begin
        $display("address beat with nonzero mask %h in test %s", ddr_mask, test_name);
        mon_errs++;
      end
      cap_line.push_back(first_line);
      cap_mask.push_back(first_mask);
      cap_addr.push_back(ddr_addr);
      in_burst = 1'b0;
    end else if (!reset && ddr_data_wen) begin
      if (in_burst) begin
        $display("new first beat before the address beat in test %s", test_name);
        mon_errs++;
      end
      first_line = ddr_data;
      first_mask = ddr_mask;
      in_burst   = 1'b1;
    end
  end

  task automatic check_line(input string what, input ddr_line_t exp, input ddr_line_t act);
    if (exp !== act) begin
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
      errs++;
    end
  endtask

  task automatic check_mask(input string what, input ddr_mask_t exp, input ddr_mask_t act);
    if (exp !== act) begin
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
      errs++;
    end
  endtask

  task automatic check_addr(input string what, input ddr_addr_t exp, input ddr_addr_t act);
    if (exp !== act) begin
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
      errs++;
    end
  endtask

  task automatic check_ack(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s %s expected %b actual %b", test_name, what, exp, act);
      errs++;
    end
  endtask

  // Holds the strobe until the client port takes it.
  task automatic drive_write(input int c, input wr_sel_t sel, input wr_addr_t addr,
                             input wr_data_t data, input logic first_nack);
    @(posedge clk);
    wr_sel[c]  <= sel;
    wr_addr[c] <= addr;
    wr_data[c] <= data;
    wr_strb[c] <= 1'b1;
    @(negedge clk);
    if (first_nack) begin
      check_ack("ack during stall", 1'b0, wr_ack[c]);
    end
    while (!wr_ack[c]) begin
      @(negedge clk);
    end
    @(posedge clk);
    wr_strb[c] <= 1'b0;
  endtask

  task automatic pulse_eob(input int which);
    @(posedge clk);
    if (which != 1) wr_eob[0] <= 1'b1;
    if (which != 0) wr_eob[1] <= 1'b1;
    @(posedge clk);
    wr_eob[0] <= 1'b0;
    wr_eob[1] <= 1'b0;
  endtask

  initial begin
    string     lines[$];
    int        stall_len[$];
    string     text;
    string     kw;
    string     arg;
    int        fd;
    int        c;
    int        n;
    int        stall_total;
    int        start_errs;
    int        passed;
    int        failed;
    wr_sel_t   sel;
    wr_addr_t  addr;
    wr_data_t  data;
    ddr_line_t exp_line[$];
    ddr_mask_t exp_mask[$];
    ddr_addr_t exp_addr[$];
    ddr_line_t l;
    ddr_mask_t m;
    ddr_addr_t a;

    void'($urandom(32'hb69a));
    clk = 1'b0;
    reset = 1'b1;
    af_afull = 1'b0;
    df_afull = 1'b0;
    for (int i = 0; i < 2; i++) begin
      wr_sel[i] = '0;
      wr_strb[i] = 1'b0;
      wr_addr[i] = '0;
      wr_data[i] = '0;
      wr_eob[i] = 1'b0;
    end
    cycle = 0;
    limit = 0;
    af_until = 0;
    df_until = 0;
    errs = 0;
    mon_errs = 0;
    in_burst = 1'b0;
    test_name = "reset";
    passed = 0;
    failed = 0;
    stall_total = 0;

    fd = $fopen("testbench/wr_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/wr_cases.txt");
      errs++;
    end else begin
      while ($fgets(text, fd) != 0) begin
        if ($sscanf(text, "%s", kw) == 1 && kw.substr(0, 0) != "#") begin
          lines.push_back(text);
          if (kw == "stall") begin
            n = 0;
            void'($sscanf(text, "%s %s %d", kw, arg, n));
            if (n == 0) n = 4 + $urandom % 12;
            stall_len.push_back(n);
            stall_total += n;
          end
        end
      end
      $fclose(fd);
    end
    limit = 64 * lines.size() + stall_total + 8;

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    foreach (lines[i]) begin
      void'($sscanf(lines[i], "%s", kw));
      case (kw)
        "test": begin
          void'($sscanf(lines[i], "%s %s", kw, test_name));
          start_errs = errs + mon_errs;
          exp_line.delete();
          exp_mask.delete();
          exp_addr.delete();
          cap_line.delete();
          cap_mask.delete();
          cap_addr.delete();
        end
        "wr", "wrx": begin
          void'($sscanf(lines[i], "%s %d %h %h %h", kw, c, sel, addr, data));
          drive_write(c, sel, addr, data, kw == "wrx");
        end
        "eob": begin
          void'($sscanf(lines[i], "%s %d", kw, c));
          pulse_eob(c);
        end
        "stall": begin
          void'($sscanf(lines[i], "%s %s", kw, arg));
          @(negedge clk);
          if (arg == "af") af_until = cycle + stall_len[0];
          else df_until = cycle + stall_len[0];
          void'(stall_len.pop_front());
        end
        "exp": begin
          void'($sscanf(lines[i], "%s %d %h %h %h", kw, c, l, m, a));
          exp_line.push_back(l);
          exp_mask.push_back(m);
          exp_addr.push_back(a);
        end
        "end": begin
          while (cap_addr.size() < exp_addr.size()) @(posedge clk);
          repeat (8) @(posedge clk);
          if (cap_addr.size() != exp_addr.size()) begin
            $display("test %s expected %0d bursts but saw %0d", test_name,
                     exp_addr.size(), cap_addr.size());
            errs++;
          end
          foreach (exp_addr[k]) begin
            if (k < cap_addr.size()) begin
              check_line($sformatf("burst %0d line", k), exp_line[k], cap_line[k]);
              check_mask($sformatf("burst %0d mask", k), exp_mask[k], cap_mask[k]);
              check_addr($sformatf("burst %0d addr", k), exp_addr[k], cap_addr[k]);
            end
          end
          if (errs + mon_errs == start_errs) begin
            passed++;
            $display("test %s passed", test_name);
          end else begin
            failed++;
            $display("test %s failed", test_name);
          end
        end
        default: begin
          $display("unknown case line: %s", lines[i]);
          errs++;
        end
      endcase
    end

    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && errs + mon_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/wr_cases.txt
# test <name> | wr/wrx <client> <sel> <addr> <data> | eob <client, 2 = both>
# stall <af|df> <cycles, 0 = random> | exp <client> <line> <mask> <addr> | end
test reset_idle
eob 0
eob 1
end
test write_combine
wr 0 3 100 0100
wr 0 3 102 0302
wr 0 3 104 0504
wr 0 3 106 0706
wr 0 3 108 0908
wr 0 3 10a 0b0a
wr 0 3 10c 0d0c
wr 0 3 10e 0f0e
eob 0
exp 0 0f0e0d0c0b0a09080706050403020100 ffff 20
end
test byte_select
wr 1 1 2000 00aa
wr 1 2 2006 bb00
wr 1 1 200c 00cc
wr 1 1 2000 0011
eob 1
exp 1 000000cc00000000bb00000000000011 1081 400
end
test miss_evict
wr 0 3 300 1234
wr 0 3 402 5678
eob 0
exp 0 00000000000000000000000000001234 0003 60
exp 0 00000000000000000000000056780000 000c 80
end
test back_pressure
wr 1 3 500 aaaa
stall df 6
wrx 1 3 600 bbbb
eob 1
exp 1 0000000000000000000000000000aaaa 0003 a0
exp 1 0000000000000000000000000000bbbb 0003 c0
end
test arbitration
wr 0 3 700 0707
wr 1 3 800 0808
eob 2
exp 1 00000000000000000000000000000808 0003 100
exp 0 00000000000000000000000000000707 0003 e0
wr 0 3 710 1717
wr 1 3 810 1818
eob 2
exp 0 00000000000000000000000000001717 0003 e2
exp 1 00000000000000000000000000001818 0003 102
end

// File: build.f
+incdir+hw
hw/client_wr_pkg.sv
hw/ddr_wr_pkg.sv
hw/ddr_wr_if.sv
hw/mem_wr_cache.sv
hw/ddr_wr_arbiter.sv
hw/ddr_wr_top.sv
testbench/ddr_wr_tb.sv

// File: Makefile
# Verilator build and run of the DDR2 write front end testbench.

VERILATOR  ?= verilator
TOP        ?= ddr_wr_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
PASS_TEXT  ?= Test OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(wildcard hw/*.sv hw/*.svh testbench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
